// ==== design/softmax_num_pkg.sv ====
package softmax_num_pkg;

  //////////////////////////////
  // Element and weight widths
  //////////////////////////////

  // Input element, unsigned 0..7
  localparam int X_W = 3;

  // Weight 2^x, largest is 128
  localparam int W_W = 8;

  // Row sum, up to 16 columns of 128
  localparam int SUM_W = 12;

  //////////////////////////////
  // Fixed-point result
  //////////////////////////////

  // Fraction bits of a probability
  localparam int FRAC_W = 8;

  // Result width, 1.0 needs the extra integer bit
  localparam int Y_W = 9;

  // Dividend is the weight shifted up by the fraction
  localparam int DIVD_W = W_W + FRAC_W;

  // Partial remainder, one bit over the divisor
  localparam int REM_W = SUM_W + 1;

endpackage

// ==== design/softmax_ctrl_pkg.sv ====
package softmax_ctrl_pkg;

  //////////////////////////////
  // Controller FSM
  //////////////////////////////

  // IDLE waits for START
  // RUN takes input elements
  // DRAIN waits for the last results
  typedef enum logic [1:0] {
    IDLE,
    RUN,
    DRAIN
  } ctrl_state_t;

  //////////////////////////////
  // Row buffer access
  //////////////////////////////

  // Opcode carried with each buffer request
  typedef enum logic [1:0] {
    MEM_IDLE,
    MEM_WRITE,
    MEM_READ
  } mem_op_t;

endpackage

// ==== design/matrix_softmax_ctrl.sv ====
`timescale 1ns/1ps

module matrix_softmax_ctrl
  import softmax_num_pkg::*;
  import softmax_ctrl_pkg::*;
#(
  parameter int MAX_J      = 16,
  parameter int IN_CREDITS = 2
) (
  input  logic                     CLK,
  input  logic                     RST,
  input  logic                     START,
  input  logic [3:0]               size_i,
  input  logic [4:0]               size_j,
  input  logic                     in_valid,
  input  logic [X_W-1:0]           in_x,
  output logic                     in_credit,
  output logic                     READY,
  output logic                     elem_valid,
  output logic [X_W-1:0]           elem_x,
  output logic                     elem_last,
  output logic [$clog2(MAX_J)-1:0] elem_col,
  output logic                     elem_bank,
  input  logic                     wr_pending,
  input  logic                     banks_full,
  input  logic                     out_done
);

  localparam int AW = $clog2(MAX_J);
  localparam int QW = (IN_CREDITS > 1) ? $clog2(IN_CREDITS) : 1;
  localparam int CW = $clog2(IN_CREDITS + 1);

  ctrl_state_t    state;
  logic [3:0]     size_i_q;
  logic [4:0]     size_j_q;
  logic [8:0]     total;
  logic [8:0]     acc_cnt;
  logic [8:0]     done_cnt;
  logic [X_W-1:0] q_x [IN_CREDITS];
  logic [QW-1:0]  q_wp;
  logic [QW-1:0]  q_rp;
  logic [CW-1:0]  q_cnt;
  logic [AW-1:0]  col_idx;
  logic [3:0]     row_idx;
  logic           accept;
  logic           fwd;
  logic           last_col;

  // Elements in the whole matrix
  assign total = size_i_q * size_j_q;

  // Producer only sends while holding a credit
  assign accept = (state == RUN) && in_valid;

  // Hand one element on when the write path and a bank are free
  assign fwd = (q_cnt != '0) && !wr_pending && !banks_full;

  assign last_col = (col_idx == AW'(size_j_q - 5'd1));

  // Credit goes back as the element leaves the queue
  assign in_credit  = fwd;
  assign elem_valid = fwd;
  assign elem_x     = q_x[q_rp];
  assign elem_col   = col_idx;
  assign elem_last  = last_col;
  // Row parity picks the bank
  assign elem_bank  = row_idx[0];

  //////////////////////////////
  // Input element queue
  //////////////////////////////

  // One slot per outstanding credit, so it never overflows
  always_ff @(posedge CLK) begin
    if (accept) begin
      q_x[q_wp] <= in_x;
    end
  end

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      q_wp  <= '0;
      q_rp  <= '0;
      q_cnt <= '0;
    end else begin
      if (accept) begin
        q_wp <= (q_wp == QW'(IN_CREDITS - 1)) ? '0 : q_wp + 1'b1;
      end
      if (fwd) begin
        q_rp <= (q_rp == QW'(IN_CREDITS - 1)) ? '0 : q_rp + 1'b1;
      end
      q_cnt <= q_cnt + CW'(accept) - CW'(fwd);
    end
  end

  //////////////////////////////
  // Row and column indices
  //////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      col_idx <= '0;
      row_idx <= '0;
    end else if (state == IDLE && START) begin
      col_idx <= '0;
      row_idx <= '0;
    end else if (fwd) begin
      // Wrap to the next row after the last column
      if (last_col) begin
        col_idx <= '0;
        row_idx <= row_idx + 4'd1;
      end else begin
        col_idx <= col_idx + 1'b1;
      end
    end
  end

  //////////////////////////////
  // Control FSM
  //////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state    <= IDLE;
      size_i_q <= '0;
      size_j_q <= '0;
      acc_cnt  <= '0;
      done_cnt <= '0;
      READY    <= 1'b0;
    end else begin
      // Single-cycle pulse
      READY <= 1'b0;
      // Results can leave while input is still running
      if (out_done) begin
        done_cnt <= done_cnt + 9'd1;
      end
      case (state)
        IDLE: begin
          if (START) begin
            size_i_q <= size_i;
            size_j_q <= size_j;
            acc_cnt  <= '0;
            done_cnt <= '0;
            state    <= RUN;
          end
        end
        RUN: begin
          if (accept) begin
            acc_cnt <= acc_cnt + 9'd1;
            // Last element in, wait for the tail of the results
            if (acc_cnt + 9'd1 == total) begin
              state <= DRAIN;
            end
          end
        end
        DRAIN: begin
          if (out_done && (done_cnt + 9'd1 == total)) begin
            READY <= 1'b1;
            state <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

endmodule

// ==== design/exp2_accumulate.sv ====
`timescale 1ns/1ps

module exp2_accumulate
  import softmax_num_pkg::*;
  import softmax_ctrl_pkg::*;
#(
  parameter int MAX_J = 16
) (
  input  logic                     CLK,
  input  logic                     RST,
  input  logic                     elem_valid,
  input  logic [X_W-1:0]           elem_x,
  input  logic                     elem_last,
  input  logic [$clog2(MAX_J)-1:0] elem_col,
  input  logic                     elem_bank,
  output logic                     wr_req,
  output mem_op_t                  wr_op,
  output logic                     wr_bank,
  output logic [$clog2(MAX_J)-1:0] wr_addr,
  output logic [W_W-1:0]           wr_data,
  input  logic                     wr_gnt,
  output logic                     wr_pending,
  output logic                     row_valid,
  output logic [SUM_W-1:0]         row_sum,
  output logic [$clog2(MAX_J):0]   row_len,
  output logic                     row_bank,
  input  logic                     row_ready
);

  localparam int AW = $clog2(MAX_J);
  localparam int LW = AW + 1;

  logic [W_W-1:0]   weight;
  logic [SUM_W-1:0] acc;
  logic             wr_last;

  // Base-two weight by shift
  assign weight = W_W'(1) << elem_x;

  assign wr_op = wr_req ? MEM_WRITE : MEM_IDLE;

  // Row end write stays pending through its grant
  // so the row hand-off is seen before the next row starts
  assign wr_pending = wr_req && (!wr_gnt || wr_last);

  //////////////////////////////
  // Write request and row sum
  //////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      wr_req    <= 1'b0;
      wr_last   <= 1'b0;
      acc       <= '0;
      row_valid <= 1'b0;
    end else begin
      if (wr_req && wr_gnt) begin
        wr_req <= 1'b0;
      end
      // New element may land in the grant cycle
      if (elem_valid) begin
        wr_req  <= 1'b1;
        wr_last <= elem_last;
        // Clear the running sum for the next row
        acc     <= elem_last ? '0 : acc + SUM_W'(weight);
      end
      if (row_valid && row_ready) begin
        row_valid <= 1'b0;
      end
      // Row goes out once its last weight is in the buffer
      if (wr_req && wr_gnt && wr_last) begin
        row_valid <= 1'b1;
      end
    end
  end

  // Write payload and finished-row summary
  always_ff @(posedge CLK) begin
    if (elem_valid) begin
      wr_data <= weight;
      wr_addr <= elem_col;
      wr_bank <= elem_bank;
      if (elem_last) begin
        row_sum  <= acc + SUM_W'(weight);
        row_len  <= LW'(elem_col) + LW'(1);
        row_bank <= elem_bank;
      end
    end
  end

endmodule

// ==== design/row_buffer_arbiter.sv ====
`timescale 1ns/1ps

module row_buffer_arbiter
  import softmax_num_pkg::*;
  import softmax_ctrl_pkg::*;
#(
  parameter int MAX_J = 16
) (
  input  logic                     CLK,
  input  logic                     RST,
  input  logic                     wr_req,
  input  mem_op_t                  wr_op,
  input  logic                     wr_bank,
  input  logic [$clog2(MAX_J)-1:0] wr_addr,
  input  logic [W_W-1:0]           wr_data,
  output logic                     wr_gnt,
  input  logic                     rd_req,
  input  mem_op_t                  rd_op,
  input  logic                     rd_bank,
  input  logic [$clog2(MAX_J)-1:0] rd_addr,
  output logic                     rd_gnt,
  output logic [W_W-1:0]           rd_data
);

  localparam int AW = $clog2(MAX_J);

  // Bank is the top address bit
  logic [W_W-1:0] mem [2*MAX_J];
  logic           rd_first;
  logic           conflict;
  mem_op_t        acc_op;
  logic [AW:0]    acc_idx;

  //////////////////////////////
  // Round-robin grant
  //////////////////////////////

  assign conflict = wr_req && rd_req;

  // One grant per cycle, last loser goes first on a conflict
  assign wr_gnt = wr_req && (!rd_req || !rd_first);
  assign rd_gnt = rd_req && (!wr_req || rd_first);

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      rd_first <= 1'b0;
    end else if (conflict) begin
      rd_first <= !rd_first;
    end
  end

  //////////////////////////////
  // Single-port weight memory
  //////////////////////////////

  // Granted side drives the one port
  always_comb begin
    if (wr_gnt) begin
      acc_op  = wr_op;
      acc_idx = {wr_bank, wr_addr};
    end else if (rd_gnt) begin
      acc_op  = rd_op;
      acc_idx = {rd_bank, rd_addr};
    end else begin
      acc_op  = MEM_IDLE;
      acc_idx = '0;
    end
  end

  // Opcode picks the access, read data lands a cycle after grant
  always_ff @(posedge CLK) begin
    case (acc_op)
      MEM_WRITE: mem[acc_idx] <= wr_data;
      MEM_READ:  rd_data <= mem[acc_idx];
      default: begin
      end
    endcase
  end

endmodule

// ==== design/normalize_divider.sv ====
`timescale 1ns/1ps

module normalize_divider
  import softmax_num_pkg::*;
  import softmax_ctrl_pkg::*;
#(
  parameter int MAX_J = 16
) (
  input  logic                     CLK,
  input  logic                     RST,
  input  logic                     row_valid,
  input  logic [SUM_W-1:0]         row_sum,
  input  logic [$clog2(MAX_J):0]   row_len,
  input  logic                     row_bank,
  output logic                     row_ready,
  output logic                     rd_req,
  output mem_op_t                  rd_op,
  output logic                     rd_bank,
  output logic [$clog2(MAX_J)-1:0] rd_addr,
  input  logic                     rd_gnt,
  input  logic [W_W-1:0]           rd_data,
  input  logic                     out_credit,
  output logic                     out_valid,
  output logic [Y_W-1:0]           out_y,
  output logic                     out_done,
  output logic                     banks_full
);

  localparam int AW    = $clog2(MAX_J);
  localparam int LW    = AW + 1;
  localparam int ST_W  = $clog2(Y_W);
  localparam int CRD_W = 8;

  // Per-result phases
  typedef enum logic [2:0] {
    N_IDLE,
    N_READ,
    N_LOAD,
    N_DIV,
    N_SEND
  } norm_phase_t;

  norm_phase_t      phase;
  logic [SUM_W-1:0] q_sum  [2];
  logic [LW-1:0]    q_len  [2];
  logic             q_bank [2];
  logic             q_wp;
  logic             q_rp;
  logic [1:0]       q_cnt;
  logic             push;
  logic             pop;
  logic [AW-1:0]    col;
  logic             last_col;
  logic [ST_W-1:0]  st_cnt;
  logic [CRD_W-1:0] crd;
  logic [DIVD_W-1:0] dividend;
  logic [REM_W-1:0] rem;
  logic [REM_W-1:0] trial;
  logic [Y_W-1:0]   dlo;
  logic [Y_W-1:0]   quot;

  //////////////////////////////
  // Row queue, waiting plus in work
  //////////////////////////////

  assign row_ready = (q_cnt != 2'd2);
  assign push      = row_valid && row_ready;

  // Two held rows, or one held and one offered, fill both banks
  assign banks_full = (q_cnt == 2'd2) || ((q_cnt == 2'd1) && row_valid);

  assign last_col = (LW'(col) + LW'(1) == q_len[q_rp]);
  assign pop      = out_valid && last_col;

  always_ff @(posedge CLK) begin
    if (push) begin
      q_sum[q_wp]  <= row_sum;
      q_len[q_wp]  <= row_len;
      q_bank[q_wp] <= row_bank;
    end
  end

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      q_wp  <= 1'b0;
      q_rp  <= 1'b0;
      q_cnt <= '0;
    end else begin
      if (push) begin
        q_wp <= !q_wp;
      end
      if (pop) begin
        q_rp <= !q_rp;
      end
      q_cnt <= q_cnt + 2'(push) - 2'(pop);
    end
  end

  //////////////////////////////
  // Weight read
  //////////////////////////////

  assign rd_req  = (phase == N_READ);
  assign rd_op   = rd_req ? MEM_READ : MEM_IDLE;
  assign rd_bank = q_bank[q_rp];
  assign rd_addr = col;

  //////////////////////////////
  // Restoring divider
  //////////////////////////////

  // Weight in fixed point, low fraction bits are zero
  assign dividend = {rd_data, {FRAC_W{1'b0}}};

  // Next remainder candidate with one more dividend bit
  assign trial = {rem[REM_W-2:0], dlo[Y_W-1]};

  // Quotient stays under 2^Y_W, so the top part starts below the sum
  always_ff @(posedge CLK) begin
    if (phase == N_LOAD) begin
      rem  <= REM_W'(dividend[DIVD_W-1:Y_W]);
      dlo  <= dividend[Y_W-1:0];
      quot <= '0;
    end else if (phase == N_DIV) begin
      dlo <= dlo << 1;
      if (trial >= REM_W'(q_sum[q_rp])) begin
        rem  <= trial - REM_W'(q_sum[q_rp]);
        quot <= {quot[Y_W-2:0], 1'b1};
      end else begin
        rem  <= trial;
        quot <= {quot[Y_W-2:0], 1'b0};
      end
    end
  end

  //////////////////////////////
  // Output under credit
  //////////////////////////////

  assign out_valid = (phase == N_SEND) && (crd != '0);
  assign out_y     = quot;
  assign out_done  = out_valid;

  // Credit count, saturates rather than wraps
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      crd <= '0;
    end else begin
      case ({out_credit, out_valid})
        2'b10: begin
          if (crd != '1) begin
            crd <= crd + 1'b1;
          end
        end
        2'b01:   crd <= crd - 1'b1;
        default: crd <= crd;
      endcase
    end
  end

  //////////////////////////////
  // Phase sequencing
  //////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      phase  <= N_IDLE;
      col    <= '0;
      st_cnt <= '0;
    end else begin
      case (phase)
        N_IDLE: begin
          if (q_cnt != '0) begin
            phase <= N_READ;
          end
        end
        // Hold the request until granted
        N_READ: begin
          if (rd_gnt) begin
            phase <= N_LOAD;
          end
        end
        // Read data valid here
        N_LOAD: begin
          st_cnt <= '0;
          phase  <= N_DIV;
        end
        N_DIV: begin
          st_cnt <= st_cnt + 1'b1;
          if (st_cnt == ST_W'(Y_W - 1)) begin
            phase <= N_SEND;
          end
        end
        // Result waits in place for a credit
        N_SEND: begin
          if (out_valid) begin
            if (last_col) begin
              col   <= '0;
              phase <= N_IDLE;
            end else begin
              col   <= col + 1'b1;
              phase <= N_READ;
            end
          end
        end
        default: phase <= N_IDLE;
      endcase
    end
  end

endmodule

// ==== design/matrix_softmax_top.sv ====
`timescale 1ns/1ps

module matrix_softmax_top
  import softmax_num_pkg::*;
  import softmax_ctrl_pkg::*;
#(
  parameter int MAX_J      = 16,
  parameter int IN_CREDITS = 2
) (
  input  logic           CLK,
  input  logic           RST,
  input  logic           START,
  input  logic [3:0]     size_i,
  input  logic [4:0]     size_j,
  input  logic           in_valid,
  input  logic [X_W-1:0] in_x,
  output logic           in_credit,
  input  logic           out_credit,
  output logic           out_valid,
  output logic [Y_W-1:0] out_y,
  output logic           READY
);

  localparam int AW = $clog2(MAX_J);

  // Controller to exponent unit
  logic           elem_valid;
  logic [X_W-1:0] elem_x;
  logic           elem_last;
  logic [AW-1:0]  elem_col;
  logic           elem_bank;
  logic           wr_pending;

  // Exponent unit write port
  logic           wr_req;
  mem_op_t        wr_op;
  logic           wr_bank;
  logic [AW-1:0]  wr_addr;
  logic [W_W-1:0] wr_data;
  logic           wr_gnt;

  // Row hand-off
  logic             row_valid;
  logic [SUM_W-1:0] row_sum;
  logic [AW:0]      row_len;
  logic             row_bank;
  logic             row_ready;

  // Normalizer read port
  logic           rd_req;
  mem_op_t        rd_op;
  logic           rd_bank;
  logic [AW-1:0]  rd_addr;
  logic           rd_gnt;
  logic [W_W-1:0] rd_data;

  // Back to the controller
  logic out_done;
  logic banks_full;

  matrix_softmax_ctrl #(
    .MAX_J      (MAX_J),
    .IN_CREDITS (IN_CREDITS)
  ) ctrl_inst (
    .CLK        (CLK),
    .RST        (RST),
    .START      (START),
    .size_i     (size_i),
    .size_j     (size_j),
    .in_valid   (in_valid),
    .in_x       (in_x),
    .in_credit  (in_credit),
    .READY      (READY),
    .elem_valid (elem_valid),
    .elem_x     (elem_x),
    .elem_last  (elem_last),
    .elem_col   (elem_col),
    .elem_bank  (elem_bank),
    .wr_pending (wr_pending),
    .banks_full (banks_full),
    .out_done   (out_done)
  );

  exp2_accumulate #(
    .MAX_J (MAX_J)
  ) exp2_inst (
    .CLK        (CLK),
    .RST        (RST),
    .elem_valid (elem_valid),
    .elem_x     (elem_x),
    .elem_last  (elem_last),
    .elem_col   (elem_col),
    .elem_bank  (elem_bank),
    .wr_req     (wr_req),
    .wr_op      (wr_op),
    .wr_bank    (wr_bank),
    .wr_addr    (wr_addr),
    .wr_data    (wr_data),
    .wr_gnt     (wr_gnt),
    .wr_pending (wr_pending),
    .row_valid  (row_valid),
    .row_sum    (row_sum),
    .row_len    (row_len),
    .row_bank   (row_bank),
    .row_ready  (row_ready)
  );

  row_buffer_arbiter #(
    .MAX_J (MAX_J)
  ) buf_inst (
    .CLK     (CLK),
    .RST     (RST),
    .wr_req  (wr_req),
    .wr_op   (wr_op),
    .wr_bank (wr_bank),
    .wr_addr (wr_addr),
    .wr_data (wr_data),
    .wr_gnt  (wr_gnt),
    .rd_req  (rd_req),
    .rd_op   (rd_op),
    .rd_bank (rd_bank),
    .rd_addr (rd_addr),
    .rd_gnt  (rd_gnt),
    .rd_data (rd_data)
  );

  normalize_divider #(
    .MAX_J (MAX_J)
  ) norm_inst (
    .CLK        (CLK),
    .RST        (RST),
    .row_valid  (row_valid),
    .row_sum    (row_sum),
    .row_len    (row_len),
    .row_bank   (row_bank),
    .row_ready  (row_ready),
    .rd_req     (rd_req),
    .rd_op      (rd_op),
    .rd_bank    (rd_bank),
    .rd_addr    (rd_addr),
    .rd_gnt     (rd_gnt),
    .rd_data    (rd_data),
    .out_credit (out_credit),
    .out_valid  (out_valid),
    .out_y      (out_y),
    .out_done   (out_done),
    .banks_full (banks_full)
  );

endmodule

// ==== sim/tb_matrix_softmax.sv ====
`timescale 1ns/1ps

module tb_matrix_softmax
  import softmax_num_pkg::*;
();

  localparam int MAX_J        = 16;
  localparam int IN_CREDITS   = 2;
  localparam int N_TESTS      = 12;
  localparam int SEED         = 96;
  // Cycles allowed per element
  localparam int CYC_PER_ELEM = 40;
  // Room for reset and held input
  localparam int MARGIN       = 600;
  // Output credits the consumer lets pile up
  localparam int HELD_MAX     = 8;

  logic           CLK;
  logic           RST;
  logic           START;
  logic [3:0]     size_i;
  logic [4:0]     size_j;
  logic           in_valid;
  logic [X_W-1:0] in_x;
  logic           in_credit;
  logic           out_credit;
  logic           out_valid;
  logic [Y_W-1:0] out_y;
  logic           READY;

  // Test table with one matrix per entry
  string tname [N_TESTS];
  int    ti    [N_TESTS];
  int    tj    [N_TESTS];
  int    teq   [N_TESTS];
  int    thold [N_TESTS];
  int    tidle [N_TESTS];
  int    tcrd  [N_TESTS];

  // Stimulus and expected results
  int    send_q [$];
  int    exp_q  [$];
  int    send_idx;
  int    start_req;
  int    cur_ni;
  int    cur_nj;
  int    in_hold;
  int    idle_pct;
  int    crd_pct;
  string cur_name;

  // Credit tracking and counters
  int prod_credits;
  int spent;
  int returned;
  int out_held;
  int got;
  int total;
  int checked;
  int errors;
  int cycle;
  int last_out_cyc;
  int limit;
  int ready_seen;

  matrix_softmax_top #(
    .MAX_J      (MAX_J),
    .IN_CREDITS (IN_CREDITS)
  ) matrix_softmax_top_inst (
    .CLK        (CLK),
    .RST        (RST),
    .START      (START),
    .size_i     (size_i),
    .size_j     (size_j),
    .in_valid   (in_valid),
    .in_x       (in_x),
    .in_credit  (in_credit),
    .out_credit (out_credit),
    .out_valid  (out_valid),
    .out_y      (out_y),
    .READY      (READY)
  );

  always #2 CLK = ~CLK;

  //////////////////////////////
  // Stimulus
  //////////////////////////////

  task automatic add_test(input int idx, input string name, input int ni, input int nj,
                          input int eq, input int hold, input int idle, input int crd);
    tname[idx] = name;
    ti[idx]    = ni;
    tj[idx]    = nj;
    teq[idx]   = eq;
    thold[idx] = hold;
    tidle[idx] = idle;
    tcrd[idx]  = crd;
  endtask

  // One clock of producer and consumer driven 1 ns after the edge
  task automatic drive_cycle();
    @(posedge CLK);
    #1;
    out_credit = (out_held < HELD_MAX) && ($urandom_range(99) < crd_pct);
    in_valid   = 1'b0;
    in_x       = X_W'($urandom_range(7));
    if (start_req != 0) begin
      START     = 1'b1;
      size_i    = 4'(cur_ni);
      size_j    = 5'(cur_nj);
      start_req = 0;
    end else begin
      START = 1'b0;
      if (in_hold > 0) begin
        in_hold--;
      end else if (send_idx < send_q.size() && prod_credits > 0 &&
                   $urandom_range(99) >= idle_pct) begin
        // Spend a credit on the next element
        in_valid = 1'b1;
        in_x     = X_W'(send_q[send_idx]);
        send_idx++;
        prod_credits--;
        spent++;
      end
    end
  endtask

  // Build one matrix and its expected results, then run it to READY
  task automatic run_matrix(input int t);
    int row_x [$];
    int xeq;
    int sum;
    int x;
    int r;
    int c;
    cur_name = tname[t];
    cur_ni   = ti[t];
    cur_nj   = tj[t];
    xeq      = $urandom_range(7);
    send_q.delete();
    if (exp_q.size() != 0) begin
      errors++;
      $display("Results left over from the previous matrix (%s)", cur_name);
      exp_q.delete();
    end
    for (r = 0; r < cur_ni; r++) begin
      row_x.delete();
      sum = 0;
      for (c = 0; c < cur_nj; c++) begin
        x = (teq[t] != 0) ? xeq : int'($urandom_range(7));
        row_x.push_back(x);
        sum += 1 << x;
      end
      // Probability is floor of the shifted weight over the row sum
      for (c = 0; c < cur_nj; c++) begin
        exp_q.push_back(((1 << row_x[c]) << FRAC_W) / sum);
        send_q.push_back(row_x[c]);
      end
    end
    send_idx   = 0;
    total      = cur_ni * cur_nj;
    got        = 0;
    in_hold    = thold[t];
    idle_pct   = tidle[t];
    crd_pct    = tcrd[t];
    ready_seen = 0;
    start_req  = 1;
    while (ready_seen == 0) begin
      drive_cycle();
    end
    if (returned != spent) begin
      errors++;
      $display("Not every element sent was accepted (%s)", cur_name);
    end
    if (prod_credits != IN_CREDITS) begin
      errors++;
      $display("Error: %s producer credits expected %0d actual %0d",
               cur_name, IN_CREDITS, prod_credits);
    end
  endtask

  //////////////////////////////
  // Monitor
  //////////////////////////////

  // Outputs are stable by the falling edge
  always @(negedge CLK) begin
    if (!RST) begin
      cycle++;
      if (in_credit) begin
        if (returned >= spent) begin
          errors++;
          $display("Input credit came back with no element spent (%s)", cur_name);
        end
        returned++;
        prod_credits++;
      end
      if (out_valid) begin
        if (out_held == 0) begin
          errors++;
          $display("out_valid raised with no output credit held (%s)", cur_name);
        end
        if (exp_q.size() == 0) begin
          errors++;
          $display("Result %0d arrived with none expected (%s)", out_y, cur_name);
        end else if (out_y !== Y_W'(exp_q[0])) begin
          errors++;
          $display("Error: %s result %0d expected %0d actual %0d",
                   cur_name, got, exp_q[0], out_y);
        end
        if (exp_q.size() != 0) begin
          void'(exp_q.pop_front());
        end
        got++;
        checked++;
        last_out_cyc = cycle;
      end
      // Same credit rule as the consumer side of the DUT
      out_held = out_held + int'(out_credit) - int'(out_valid);
      if (READY) begin
        if (ready_seen != 0) begin
          errors++;
          $display("READY pulsed with no matrix in flight (%s)", cur_name);
        end else begin
          if (got != total) begin
            errors++;
            $display("Error: %s result count expected %0d actual %0d", cur_name, total, got);
          end
          if (cycle != last_out_cyc + 1) begin
            errors++;
            $display("READY did not follow the last result by one cycle (%s)", cur_name);
          end
        end
        ready_seen = 1;
      end
      if (cycle >= limit) begin
        $display("Timeout after %0d cycles, matrix %s did not finish", limit, cur_name);
        $display(">>> FAIL");
        $finish;
      end
    end
  end

  //////////////////////////////
  // Test sequence
  //////////////////////////////

  initial begin
    int t;
    int total_elems;
    void'($urandom(SEED));
    CLK          = 1'b0;
    RST          = 1'b1;
    START        = 1'b0;
    size_i       = '0;
    size_j       = '0;
    in_valid     = 1'b0;
    in_x         = '0;
    out_credit   = 1'b0;
    prod_credits = IN_CREDITS;
    spent        = 0;
    returned     = 0;
    out_held     = 0;
    got          = 0;
    total        = 0;
    checked      = 0;
    errors       = 0;
    cycle        = 0;
    last_out_cyc = 0;
    send_idx     = 0;
    start_req    = 0;
    in_hold      = 0;
    idle_pct     = 0;
    crd_pct      = 0;
    // A READY before any START is an error
    ready_seen   = 1;
    cur_name     = "reset";

    // Directed rows first and random sizes after
    add_test(0, "single", 1, 1, 1, 0, 0, 75);
    add_test(1, "equal_row", 3, 7, 1, 0, 0, 75);
    add_test(2, "equal_full", 2, 16, 1, 0, 0, 75);
    for (t = 3; t < 7; t++) begin
      add_test(t, "random", $urandom_range(15, 1), $urandom_range(16, 1), 0, 0, 20, 60);
    end
    // Producer holds off and then sends sparsely
    add_test(7, "late_input", $urandom_range(15, 1), $urandom_range(16, 1), 0, 30, 80, 70);
    add_test(8, "late_input", $urandom_range(15, 1), $urandom_range(16, 1), 0, 30, 80, 70);
    // Output credits trickle in
    add_test(9, "credit_starve", $urandom_range(15, 1), $urandom_range(16, 1), 0, 0, 10, 5);
    add_test(10, "credit_starve", $urandom_range(15, 1), $urandom_range(16, 1), 0, 0, 10, 5);
    add_test(11, "back_to_back", $urandom_range(15, 1), $urandom_range(16, 1), 0, 0, 0, 100);

    total_elems = 0;
    for (t = 0; t < N_TESTS; t++) begin
      total_elems += ti[t] * tj[t];
    end
    limit = total_elems * CYC_PER_ELEM + MARGIN;

    repeat (2) @(posedge CLK);
    #1;
    RST = 1'b0;

    // Each START follows the previous READY directly
    for (t = 0; t < N_TESTS; t++) begin
      run_matrix(t);
    end

    // Quiet tail catches stray results or READY pulses
    cur_name = "tail";
    repeat (20) drive_cycle();

    $display("Results checked: %0d, matrices: %0d, errors: %0d", checked, N_TESTS, errors);
    if (errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

// ==== tb.f ====
design/softmax_num_pkg.sv
design/softmax_ctrl_pkg.sv
design/matrix_softmax_ctrl.sv
design/exp2_accumulate.sv
design/row_buffer_arbiter.sv
design/normalize_divider.sv
design/matrix_softmax_top.sv
sim/tb_matrix_softmax.sv

// ==== Makefile ====
# Verilator flow for the matrix softmax testbench

VERILATOR ?= verilator
TOP       ?= tb_matrix_softmax
RTL_TOP   ?= matrix_softmax_top
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= >>> PASS
VFLAGS    ?= --timing -Wno-fatal

SOURCES := $(shell cat $(FILELIST))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TOP)
	-$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	grep -qxF "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
